// File: ecc_bank.sv
`timescale 1ns/1ps

module ecc_bank (
   input  logic                        clk,
   input  logic                        rst_l,
   input  logic                        we,
   input  logic                        clear,
   input  logic [ecc_pkg::DATA_W-1:0]  code_data,
   input  logic [ecc_pkg::ECC_W-1:0]   code_ecc,
   output logic [ecc_pkg::DATA_W-1:0]  word_data,
   output logic [ecc_pkg::ECC_W-1:0]   word_ecc,
   output logic                        word_written
);

   logic [ecc_pkg::CODE_W-1:0] code_q;
   logic                       written_q;

   // clear beats a write in the same cycle.
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         code_q    <= '0;
         written_q <= 1'b0;
      end else if (clear) begin
         code_q    <= '0;
         written_q <= 1'b0;
      end else if (we) begin
         code_q    <= {code_ecc, code_data};
         written_q <= 1'b1;
      end
   end

   assign word_data    = code_q[ecc_pkg::DATA_W-1:0];
   assign word_ecc     = code_q[ecc_pkg::CODE_W-1:ecc_pkg::DATA_W];
   assign word_written = written_q;

endmodule

// File: ecc_pkg.sv
package ecc_pkg;

   // hamming code for a 32-bit word, plus one overall parity bit.
   localparam int DATA_W = 32;
   localparam int ECC_W  = 7;
   localparam int SYN_W  = 6;
   localparam int CODE_W = 39;

   // data bits fill positions 1 to 38 that are not powers of two.
   function automatic logic [ECC_W-1:0] check_bits(input logic [DATA_W-1:0] data);
      logic [ECC_W-1:0] cb;
      int               d;
      cb = '0;
      d  = 0;
      for (int p = 1; p < CODE_W; p++) begin
         if ((p & (p - 1)) != 0) begin
            for (int k = 0; k < SYN_W; k++) begin
               if (((p >> k) & 1) == 1) begin
                  cb[k] = cb[k] ^ data[d];
               end
            end
            d++;
         end
      end
      // overall parity across data and the six hamming bits.
      cb[ECC_W-1] = (^data) ^ (^cb[SYN_W-1:0]);
      return cb;
   endfunction

   // bits 5:0 give the failing position, bit 6 the parity of the stored codeword.
   function automatic logic [ECC_W-1:0] syndrome(input logic [DATA_W-1:0] data,
                                                 input logic [ECC_W-1:0]  ecc);
      logic [ECC_W-1:0] cb;
      logic [ECC_W-1:0] syn;
      cb                = check_bits(data);
      syn[SYN_W-1:0]    = cb[SYN_W-1:0] ^ ecc[SYN_W-1:0];
      syn[ECC_W-1]      = (^data) ^ (^ecc);
      return syn;
   endfunction

endpackage

// File: ecc_read_port.sv
`timescale 1ns/1ps

module ecc_read_port (
   input  logic                                                 clk,
   input  logic                                                 rst_l,
   input  logic                                                 rd_en,
   input  logic [store_pkg::ADDR_W-1:0]                         rd_addr,
   input  logic                                                 sed_ded,
   input  logic [store_pkg::NUM_WORDS-1:0][ecc_pkg::DATA_W-1:0] all_data,
   input  logic [store_pkg::NUM_WORDS-1:0][ecc_pkg::ECC_W-1:0]  all_ecc,
   input  logic [store_pkg::NUM_WORDS-1:0]                      all_written,
   output logic                                                 rd_valid,
   output logic                                                 rd_hit,
   output logic [ecc_pkg::DATA_W-1:0]                           rd_data,
   output logic [ecc_pkg::ECC_W-1:0]                            rd_ecc,
   output logic                                                 single_err,
   output logic                                                 double_err
);

   logic [ecc_pkg::DATA_W-1:0] sel_data;
   logic [ecc_pkg::ECC_W-1:0]  sel_ecc;
   logic                       sel_written;
   logic [ecc_pkg::ECC_W-1:0]  syn;
   logic [ecc_pkg::ECC_W-1:0]  syn_eff;
   logic                       err_any;
   logic                       single;
   logic                       double;
   logic [ecc_pkg::CODE_W-1:0] code_in;
   logic [ecc_pkg::CODE_W-1:0] err_mask;
   logic [ecc_pkg::CODE_W-1:0] code_fix;
   logic [ecc_pkg::DATA_W-1:0] fix_data;
   logic [ecc_pkg::ECC_W-1:0]  fix_ecc;

   assign sel_data    = all_data[rd_addr];
   assign sel_ecc     = all_ecc[rd_addr];
   assign sel_written = all_written[rd_addr];

   // detect-only mode turns every error into a double.
   assign syn     = ecc_pkg::syndrome(sel_data, sel_ecc);
   assign syn_eff = {syn[ecc_pkg::ECC_W-1] & ~sed_ded, syn[ecc_pkg::SYN_W-1:0]};
   assign err_any = sel_written & (syn_eff != '0);
   assign single  = err_any & syn_eff[ecc_pkg::ECC_W-1];
   assign double  = err_any & ~syn_eff[ecc_pkg::ECC_W-1];

   // codeword bit p-1 holds position p; the top bit is the overall parity.
   always_comb begin
      int d;
      int k;
      d = 0;
      k = 0;
      for (int p = 1; p < ecc_pkg::CODE_W; p++) begin
         if ((p & (p - 1)) == 0) begin
            code_in[p-1] = sel_ecc[k];
            k++;
         end else begin
            code_in[p-1] = sel_data[d];
            d++;
         end
      end
      code_in[ecc_pkg::CODE_W-1] = sel_ecc[ecc_pkg::ECC_W-1];
   end

   // zero position means the parity bit itself failed.
   always_comb begin
      for (int i = 0; i < ecc_pkg::CODE_W - 1; i++) begin
         err_mask[i] = (syn_eff[ecc_pkg::SYN_W-1:0] == ecc_pkg::SYN_W'(i + 1));
      end
      err_mask[ecc_pkg::CODE_W-1] = (syn_eff[ecc_pkg::SYN_W-1:0] == '0);
   end

   assign code_fix = single ? (code_in ^ err_mask) : code_in;

   always_comb begin
      int d;
      int k;
      d = 0;
      k = 0;
      for (int p = 1; p < ecc_pkg::CODE_W; p++) begin
         if ((p & (p - 1)) == 0) begin
            fix_ecc[k] = code_fix[p-1];
            k++;
         end else begin
            fix_data[d] = code_fix[p-1];
            d++;
         end
      end
      fix_ecc[ecc_pkg::ECC_W-1] = code_fix[ecc_pkg::CODE_W-1];
   end

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         rd_valid   <= 1'b0;
         rd_hit     <= 1'b0;
         single_err <= 1'b0;
         double_err <= 1'b0;
      end else begin
         rd_valid   <= rd_en;
         rd_hit     <= rd_en & sel_written;
         single_err <= rd_en & single;
         double_err <= rd_en & double;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= fix_data;
         rd_ecc  <= fix_ecc;
      end
   end

endmodule

// File: ecc_store_assert.sv
`timescale 1ns/1ps

module ecc_store_assert (
   input logic clk,
   input logic rst_l,
   input logic rd_en,
   input logic rd_valid,
   input logic single_err,
   input logic double_err
);

   int unsigned fails = 0;

   // an error is either single or double, never both.
   flags_exclusive: assert property (@(posedge clk) disable iff (!rst_l)
      !(single_err && double_err))
   else begin
      fails++;
      $error("single_err and double_err are high together");
   end

   flag_needs_valid: assert property (@(posedge clk) disable iff (!rst_l)
      (single_err || double_err) |-> rd_valid)
   else begin
      fails++;
      $error("error flag is high without rd_valid");
   end

   // one cycle read latency.
   valid_after_read: assert property (@(posedge clk) disable iff (!rst_l)
      rd_en |=> rd_valid)
   else begin
      fails++;
      $error("rd_valid did not follow rd_en");
   end

endmodule

// File: ecc_store_tb.sv
`timescale 1ns/1ps

module ecc_store_tb;

   typedef enum logic [2:0] {OP_WRITE, OP_RAW, OP_READ, OP_CLEAR, OP_RDWR} op_t;

   typedef struct packed {
      op_t                          op;
      logic [store_pkg::ADDR_W-1:0] addr;
      logic [ecc_pkg::DATA_W-1:0]   data;
      logic [ecc_pkg::ECC_W-1:0]    ecc;
      logic [ecc_pkg::CODE_W-1:0]   flip;
      logic                         sed;
      logic                         exp_valid;
      logic                         exp_hit;
      logic [ecc_pkg::DATA_W-1:0]   exp_data;
      logic [ecc_pkg::ECC_W-1:0]    exp_ecc;
      logic                         exp_single;
      logic                         exp_double;
   } entry_t;

   logic                         clk;
   logic                         rst_l;
   logic                         wr_en;
   logic                         wr_raw;
   logic [store_pkg::ADDR_W-1:0] wr_addr;
   logic [ecc_pkg::DATA_W-1:0]   wr_data;
   logic [ecc_pkg::ECC_W-1:0]    wr_ecc;
   logic                         clear;
   logic                         sed_ded;
   logic                         rd_en;
   logic [store_pkg::ADDR_W-1:0] rd_addr;
   logic                         rd_valid;
   logic                         rd_hit;
   logic [ecc_pkg::DATA_W-1:0]   rd_data;
   logic [ecc_pkg::ECC_W-1:0]    rd_ecc;
   logic                         single_err;
   logic                         double_err;

   entry_t      tbl[$];
   string       names[$];
   logic        table_ready = 1'b0;
   logic [31:0] lcg_state = 32'ha89e;

   // model of the stored words.
   logic [ecc_pkg::DATA_W-1:0] m_data[store_pkg::NUM_WORDS];
   logic [ecc_pkg::ECC_W-1:0]  m_ecc[store_pkg::NUM_WORDS];
   logic                       m_written[store_pkg::NUM_WORDS];

   tb_clock u_clock (
      .clk (clk)
   );

   ecc_store_top DUT (
      .clk        (clk),
      .rst_l      (rst_l),
      .wr_en      (wr_en),
      .wr_raw     (wr_raw),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .wr_ecc     (wr_ecc),
      .clear      (clear),
      .sed_ded    (sed_ded),
      .rd_en      (rd_en),
      .rd_addr    (rd_addr),
      .rd_valid   (rd_valid),
      .rd_hit     (rd_hit),
      .rd_data    (rd_data),
      .rd_ecc     (rd_ecc),
      .single_err (single_err),
      .double_err (double_err)
   );

   bind ecc_read_port ecc_store_assert u_assert (
      .clk        (clk),
      .rst_l      (rst_l),
      .rd_en      (rd_en),
      .rd_valid   (rd_valid),
      .single_err (single_err),
      .double_err (double_err)
   );

   function logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // codeword mask with bits 31:0 data and bits 38:32 check bits.
   function automatic logic [ecc_pkg::CODE_W-1:0] code_bit(input int n);
      logic [ecc_pkg::CODE_W-1:0] m;
      m    = '0;
      m[n] = 1'b1;
      return m;
   endfunction

   // flip the bit at hamming position pos or the parity bit for zero.
   task automatic correct_bit(input int pos, inout logic [ecc_pkg::DATA_W-1:0] d,
                              inout logic [ecc_pkg::ECC_W-1:0] e);
      int di;
      int ci;
      di = 0;
      ci = 0;
      if (pos == 0) begin
         e[ecc_pkg::ECC_W-1] = ~e[ecc_pkg::ECC_W-1];
      end
      for (int p = 1; p < ecc_pkg::CODE_W; p++) begin
         if ((p & (p - 1)) == 0) begin
            if (p == pos) begin
               e[ci] = ~e[ci];
            end
            ci++;
         end else begin
            if (p == pos) begin
               d[di] = ~d[di];
            end
            di++;
         end
      end
   endtask

   task automatic model_read(input int a, input logic sed, output logic hit,
                             output logic [ecc_pkg::DATA_W-1:0] d,
                             output logic [ecc_pkg::ECC_W-1:0] e,
                             output logic sgl, output logic dbl);
      logic [ecc_pkg::ECC_W-1:0] cb;
      logic [ecc_pkg::ECC_W-1:0] syn;
      hit = m_written[a];
      d   = m_data[a];
      e   = m_ecc[a];
      sgl = 1'b0;
      dbl = 1'b0;
      if (hit) begin
         cb       = ecc_pkg::check_bits(d);
         syn[5:0] = cb[5:0] ^ e[5:0];
         // overall parity of the stored codeword, dropped in detect-only mode.
         syn[6]   = (^{d, e}) & ~sed;
         if (syn != '0) begin
            if (syn[6]) begin
               sgl = 1'b1;
               correct_bit(int'(syn[5:0]), d, e);
            end else begin
               dbl = 1'b1;
            end
         end
      end
   endtask

   task automatic add_entry(input string name, input op_t op, input int addr,
                            input logic [ecc_pkg::CODE_W-1:0] flip, input logic sed);
      entry_t      e;
      logic [31:0] clean;
      e      = '0;
      e.op   = op;
      e.addr = store_pkg::ADDR_W'(addr);
      e.flip = flip;
      e.sed  = sed;
      if (op != OP_READ) begin
         clean  = lcg_next();
         e.data = clean ^ flip[ecc_pkg::DATA_W-1:0];
         e.ecc  = ecc_pkg::check_bits(clean) ^ flip[ecc_pkg::CODE_W-1:ecc_pkg::DATA_W];
      end
      if (op == OP_READ || op == OP_RDWR) begin
         e.exp_valid = 1'b1;
         model_read(addr, sed, e.exp_hit, e.exp_data, e.exp_ecc, e.exp_single, e.exp_double);
      end
      case (op)
         OP_WRITE, OP_RDWR: begin
            m_data[addr]    = e.data;
            m_ecc[addr]     = ecc_pkg::check_bits(e.data);
            m_written[addr] = 1'b1;
         end
         OP_RAW: begin
            m_data[addr]    = e.data;
            m_ecc[addr]     = e.ecc;
            m_written[addr] = 1'b1;
         end
         OP_CLEAR: begin
            // clear wins over the write driven with it.
            for (int i = 0; i < store_pkg::NUM_WORDS; i++) begin
               m_data[i]    = '0;
               m_ecc[i]     = '0;
               m_written[i] = 1'b0;
            end
         end
         default: begin
         end
      endcase
      tbl.push_back(e);
      names.push_back(name);
   endtask

   task automatic build_table();
      for (int i = 0; i < store_pkg::NUM_WORDS; i++) begin
         m_data[i]    = '0;
         m_ecc[i]     = '0;
         m_written[i] = 1'b0;
      end
      add_entry("read empty 0", OP_READ, 0, '0, 1'b0);
      add_entry("read empty 5", OP_READ, 5, '0, 1'b0);
      for (int a = 0; a < store_pkg::NUM_WORDS; a++) begin
         add_entry($sformatf("write %0d", a), OP_WRITE, a, '0, 1'b0);
      end
      for (int a = 0; a < store_pkg::NUM_WORDS; a++) begin
         add_entry($sformatf("read back %0d", a), OP_READ, a, '0, 1'b0);
      end
      add_entry("raw data bit 0", OP_RAW, 1, code_bit(0), 1'b0);
      add_entry("single data bit 0", OP_READ, 1, '0, 1'b0);
      add_entry("raw data bit 31", OP_RAW, 2, code_bit(31), 1'b0);
      add_entry("single data bit 31", OP_READ, 2, '0, 1'b0);
      add_entry("raw check bit 2", OP_RAW, 3, code_bit(34), 1'b0);
      add_entry("single check bit 2", OP_READ, 3, '0, 1'b0);
      add_entry("raw check bit 6", OP_RAW, 4, code_bit(38), 1'b0);
      add_entry("single check bit 6", OP_READ, 4, '0, 1'b0);
      add_entry("raw two data bits", OP_RAW, 6, code_bit(3) | code_bit(17), 1'b0);
      add_entry("double data bits", OP_READ, 6, '0, 1'b0);
      add_entry("raw data and check", OP_RAW, 7, code_bit(5) | code_bit(33), 1'b0);
      add_entry("double data and check", OP_READ, 7, '0, 1'b0);
      add_entry("raw for detect only", OP_RAW, 0, code_bit(9), 1'b0);
      add_entry("detect only single", OP_READ, 0, '0, 1'b1);
      add_entry("same word corrected", OP_READ, 0, '0, 1'b0);
      add_entry("detect only clean", OP_READ, 5, '0, 1'b1);
      add_entry("read with write", OP_RDWR, 5, '0, 1'b0);
      add_entry("read after write", OP_READ, 5, '0, 1'b0);
      add_entry("clear over write", OP_CLEAR, 2, '0, 1'b0);
      add_entry("cleared 2", OP_READ, 2, '0, 1'b0);
      add_entry("cleared 6", OP_READ, 6, '0, 1'b0);
      add_entry("write after clear", OP_WRITE, 3, '0, 1'b0);
      add_entry("read after clear", OP_READ, 3, '0, 1'b0);
      add_entry("cleared 0", OP_READ, 0, '0, 1'b0);
   endtask

   task automatic check_data(input string name, input logic [ecc_pkg::DATA_W-1:0] exp,
                             input logic [ecc_pkg::DATA_W-1:0] act);
      if (act !== exp) begin
         $display("error %s expected %h actual %h", name, exp, act);
         $display("Checks failed");
         $fatal(1, "data mismatch");
      end
   endtask

   task automatic check_ecc(input string name, input logic [ecc_pkg::ECC_W-1:0] exp,
                            input logic [ecc_pkg::ECC_W-1:0] act);
      if (act !== exp) begin
         $display("error %s expected %h actual %h", name, exp, act);
         $display("Checks failed");
         $fatal(1, "check bit mismatch");
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("error %s expected %b actual %b", name, exp, act);
         $display("Checks failed");
         $fatal(1, "flag mismatch");
      end
   endtask

   task automatic drive_entry(input entry_t e);
      wr_en   = (e.op == OP_WRITE || e.op == OP_RAW || e.op == OP_CLEAR || e.op == OP_RDWR);
      wr_raw  = (e.op == OP_RAW);
      wr_addr = e.addr;
      wr_data = e.data;
      wr_ecc  = e.ecc;
      clear   = (e.op == OP_CLEAR);
      sed_ded = e.sed;
      rd_en   = (e.op == OP_READ || e.op == OP_RDWR);
      rd_addr = e.addr;
   endtask

   task automatic check_entry(input entry_t e, input string name);
      check_flag({name, " rd_valid"}, e.exp_valid, rd_valid);
      if (e.exp_valid) begin
         check_flag({name, " rd_hit"}, e.exp_hit, rd_hit);
         check_data({name, " rd_data"}, e.exp_data, rd_data);
         check_ecc({name, " rd_ecc"}, e.exp_ecc, rd_ecc);
         check_flag({name, " single_err"}, e.exp_single, single_err);
         check_flag({name, " double_err"}, e.exp_double, double_err);
      end
   endtask

   initial begin : watchdog
      longint limit_ns;
      wait (table_ready);
      // reset plus four cycles per entry, then a margin.
      limit_ns = (4 + 4 * longint'(tbl.size())) * 8 + 200;
      #(limit_ns);
      $display("timeout: the run did not finish within %0d ns", limit_ns);
      $display("Checks failed");
      $fatal(1, "watchdog expired");
   end

   initial begin
      rst_l   = 1'b0;
      wr_en   = 1'b0;
      wr_raw  = 1'b0;
      wr_addr = '0;
      wr_data = '0;
      wr_ecc  = '0;
      clear   = 1'b0;
      sed_ded = 1'b0;
      rd_en   = 1'b0;
      rd_addr = '0;
      build_table();
      table_ready = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      rst_l = 1'b1;
      check_flag("reset rd_valid", 1'b0, rd_valid);
      check_flag("reset single_err", 1'b0, single_err);
      check_flag("reset double_err", 1'b0, double_err);
      for (int i = 0; i < tbl.size(); i++) begin
         drive_entry(tbl[i]);
         @(posedge clk);
         #1;
         wr_en = 1'b0;
         clear = 1'b0;
         rd_en = 1'b0;
         check_entry(tbl[i], names[i]);
      end
      @(posedge clk);
      #1;
      if (DUT.u_read_port.u_assert.fails == 0) begin
         $display("All checks passed");
         $finish;
      end else begin
         $display("%0d assertion failures", DUT.u_read_port.u_assert.fails);
         $display("Checks failed");
         $fatal(1, "assertion failures");
      end
   end

endmodule

// File: ecc_store_top.sv
`timescale 1ns/1ps

module ecc_store_top (
   input  logic                         clk,
   input  logic                         rst_l,
   input  logic                         wr_en,
   input  logic                         wr_raw,
   input  logic [store_pkg::ADDR_W-1:0] wr_addr,
   input  logic [ecc_pkg::DATA_W-1:0]   wr_data,
   input  logic [ecc_pkg::ECC_W-1:0]    wr_ecc,
   input  logic                         clear,
   input  logic                         sed_ded,
   input  logic                         rd_en,
   input  logic [store_pkg::ADDR_W-1:0] rd_addr,
   output logic                         rd_valid,
   output logic                         rd_hit,
   output logic [ecc_pkg::DATA_W-1:0]   rd_data,
   output logic [ecc_pkg::ECC_W-1:0]    rd_ecc,
   output logic                         single_err,
   output logic                         double_err
);

   logic [ecc_pkg::DATA_W-1:0]                           code_data;
   logic [ecc_pkg::ECC_W-1:0]                            code_ecc;
   logic [store_pkg::NUM_WORDS-1:0]                      bank_we;
   logic [store_pkg::NUM_WORDS-1:0][ecc_pkg::DATA_W-1:0] word_data;
   logic [store_pkg::NUM_WORDS-1:0][ecc_pkg::ECC_W-1:0]  word_ecc;
   logic [store_pkg::NUM_WORDS-1:0]                      word_written;

   ecc_write_port u_write_port (
      .wr_en     (wr_en),
      .wr_raw    (wr_raw),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .wr_ecc    (wr_ecc),
      .code_data (code_data),
      .code_ecc  (code_ecc),
      .bank_we   (bank_we)
   );

   for (genvar i = 0; i < store_pkg::NUM_WORDS; i++) begin : g_bank
      ecc_bank u_bank (
         .clk          (clk),
         .rst_l        (rst_l),
         .we           (bank_we[i]),
         .clear        (clear),
         .code_data    (code_data),
         .code_ecc     (code_ecc),
         .word_data    (word_data[i]),
         .word_ecc     (word_ecc[i]),
         .word_written (word_written[i])
      );
   end

   ecc_read_port u_read_port (
      .clk         (clk),
      .rst_l       (rst_l),
      .rd_en       (rd_en),
      .rd_addr     (rd_addr),
      .sed_ded     (sed_ded),
      .all_data    (word_data),
      .all_ecc     (word_ecc),
      .all_written (word_written),
      .rd_valid    (rd_valid),
      .rd_hit      (rd_hit),
      .rd_data     (rd_data),
      .rd_ecc      (rd_ecc),
      .single_err  (single_err),
      .double_err  (double_err)
   );

endmodule

// File: ecc_write_port.sv
`timescale 1ns/1ps

module ecc_write_port (
   input  logic                               wr_en,
   input  logic                               wr_raw,
   input  logic [store_pkg::ADDR_W-1:0]       wr_addr,
   input  logic [ecc_pkg::DATA_W-1:0]         wr_data,
   input  logic [ecc_pkg::ECC_W-1:0]          wr_ecc,
   output logic [ecc_pkg::DATA_W-1:0]         code_data,
   output logic [ecc_pkg::ECC_W-1:0]          code_ecc,
   output logic [store_pkg::NUM_WORDS-1:0]    bank_we
);

   logic [ecc_pkg::ECC_W-1:0] enc_ecc;

   assign enc_ecc   = ecc_pkg::check_bits(wr_data);
   assign code_data = wr_data;

   // raw writes keep the caller's check bits, error patterns included.
   assign code_ecc  = wr_raw ? wr_ecc : enc_ecc;

   // one-hot bank select.
   always_comb begin
      bank_we          = '0;
      bank_we[wr_addr] = wr_en;
   end

endmodule

// File: run.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log.
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f sources.f --top-module ecc_store_tb -o ecc_store_sim &&
{ ./obj_dir/ecc_store_sim > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -qx "All checks passed" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: sources.f
ecc_pkg.sv
store_pkg.sv
ecc_write_port.sv
ecc_bank.sv
ecc_read_port.sv
ecc_store_top.sv
tb_clock.sv
ecc_store_assert.sv
ecc_store_tb.sv

// File: store_pkg.sv
package store_pkg;

   // eight words, one bank each.
   localparam int NUM_WORDS = 8;
   localparam int ADDR_W    = 3;

endpackage

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
   output logic clk
);

   // 8 ns period.
   initial begin
      clk = 1'b0;
      forever begin
         #4 clk = ~clk;
      end
   end

endmodule
